/* common/tlb_pkg.sv */
package tlb_pkg;

    // tlb geometry
    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;

    // address and register image layout
    localparam int VADDR_W = 32;
    localparam int VPN2_W  = 19;
    localparam int ODD_BIT = 12;
    localparam int ASID_W  = 8;

    // entry-lo fields
    localparam int PFN_W   = 20;
    localparam int CACHE_W = 3;

    localparam logic [CACHE_W-1:0] CACHE_UNCACHED = 3'd2;

    // address bits 31..29 of the unmapped segments
    localparam logic [2:0] SEG_KSEG0 = 3'd4;
    localparam logic [2:0] SEG_KSEG1 = 3'd5;

    // probe index on a miss, P bit only
    localparam logic [VADDR_W-1:0] PROBE_MISS = 32'h8000_0000;

    // one page of a pair
    typedef struct packed {
        logic [PFN_W-1:0]   pfn;
        logic [CACHE_W-1:0] c;
        logic               d;
        logic               v;
    } tlb_page_t;

    // one joint tlb entry, even page in page0
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

endpackage

/* flist.f */
common/tlb_pkg.sv
tlb/tlb_entry_array.sv
tlb/tlb_cam.sv
src/tlb_xlate.sv
src/tlb_top.sv
testbench/tlb_checker.sv
testbench/tb_tlb.sv

/* src/tlb_top.sv */
module tlb_top
    import tlb_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,

    // write port, tlbwi/tlbwr
    input  logic                    i_we,
    input  logic [TLB_IDX_W-1:0]    i_w_index,
    input  logic [VADDR_W-1:0]      i_w_hi,
    input  logic [VADDR_W-1:0]      i_w_lo0,
    input  logic [VADDR_W-1:0]      i_w_lo1,

    // read port, tlbr
    input  logic [TLB_IDX_W-1:0]    i_r_index,

    // search ports
    input  logic                    i_inst_en,
    input  logic [VADDR_W-1:0]      i_inst_vaddr,
    input  logic                    i_data_ren,
    input  logic                    i_data_wen,
    input  logic [VADDR_W-1:0]      i_data_vaddr,
    input  logic                    i_op_tlbp,

    output logic [VADDR_W-1:0]      o_r_hi,
    output logic [VADDR_W-1:0]      o_r_lo0,
    output logic [VADDR_W-1:0]      o_r_lo1,
    output logic [VADDR_W-1:0]      o_p_index,

    output logic [PFN_W-1:0]        o_inst_tag,
    output logic                    o_inst_uncached,
    output logic [PFN_W-1:0]        o_data_tag,
    output logic                    o_data_uncached,

    output logic                    o_i_refill,
    output logic                    o_i_invalid,
    output logic                    o_d_refill,
    output logic                    o_d_invalid,
    output logic                    o_d_modify
);

    tlb_entry_t [TLB_NUM-1:0] entries;
    logic                     inst_found;
    logic                     data_found;
    tlb_page_t                inst_page;
    tlb_page_t                data_page;

    tlb_entry_array u_entry_array (
        .clk        (clk),
        .resetn     (resetn),
        .i_we       (i_we),
        .i_w_index  (i_w_index),
        .i_w_hi     (i_w_hi),
        .i_w_lo0    (i_w_lo0),
        .i_w_lo1    (i_w_lo1),
        .i_r_index  (i_r_index),
        .o_entries  (entries),
        .o_r_hi     (o_r_hi),
        .o_r_lo0    (o_r_lo0),
        .o_r_lo1    (o_r_lo1)
    );

    // searches see stored entries only
    tlb_cam u_cam (
        .i_entries      (entries),
        .i_w_hi         (i_w_hi),
        .i_op_tlbp      (i_op_tlbp),
        .i_inst_vaddr   (i_inst_vaddr),
        .i_data_vaddr   (i_data_vaddr),
        .o_inst_found   (inst_found),
        .o_data_found   (data_found),
        .o_inst_page    (inst_page),
        .o_data_page    (data_page),
        .o_p_index      (o_p_index)
    );

    tlb_xlate u_xlate (
        .i_inst_en          (i_inst_en),
        .i_inst_vaddr       (i_inst_vaddr),
        .i_inst_found       (inst_found),
        .i_inst_page        (inst_page),
        .i_data_ren         (i_data_ren),
        .i_data_wen         (i_data_wen),
        .i_data_vaddr       (i_data_vaddr),
        .i_data_found       (data_found),
        .i_data_page        (data_page),
        .o_inst_tag         (o_inst_tag),
        .o_data_tag         (o_data_tag),
        .o_inst_uncached    (o_inst_uncached),
        .o_data_uncached    (o_data_uncached),
        .o_i_refill         (o_i_refill),
        .o_i_invalid        (o_i_invalid),
        .o_d_refill         (o_d_refill),
        .o_d_invalid        (o_d_invalid),
        .o_d_modify         (o_d_modify)
    );

endmodule

/* src/tlb_xlate.sv */
module tlb_xlate
    import tlb_pkg::*;
(
    input  logic                i_inst_en,
    input  logic [VADDR_W-1:0]  i_inst_vaddr,
    input  logic                i_inst_found,
    input  tlb_page_t           i_inst_page,

    input  logic                i_data_ren,
    input  logic                i_data_wen,
    input  logic [VADDR_W-1:0]  i_data_vaddr,
    input  logic                i_data_found,
    input  tlb_page_t           i_data_page,

    output logic [PFN_W-1:0]    o_inst_tag,
    output logic [PFN_W-1:0]    o_data_tag,
    output logic                o_inst_uncached,
    output logic                o_data_uncached,

    output logic                o_i_refill,
    output logic                o_i_invalid,
    output logic                o_d_refill,
    output logic                o_d_invalid,
    output logic                o_d_modify
);

    logic [2:0] inst_seg;
    logic [2:0] data_seg;
    logic       inst_unmapped;
    logic       data_unmapped;
    logic       data_access;

    // unmapped segments translate by dropping the top three bits
    function automatic logic [PFN_W-1:0] xlate_tag(
        input logic               unmapped,
        input logic [VADDR_W-1:0] va,
        input tlb_page_t          pg
    );
        if (unmapped) begin
            return {3'b000, va[VADDR_W-4:ODD_BIT]};
        end
        return pg.pfn;
    endfunction

    function automatic logic xlate_uncached(
        input logic [2:0] seg,
        input logic       found,
        input tlb_page_t  pg
    );
        if (seg == SEG_KSEG1) begin
            return 1'b1;
        end
        // kseg0 is always cached
        if (seg == SEG_KSEG0) begin
            return 1'b0;
        end
        return found && (pg.c == CACHE_UNCACHED);
    endfunction

    assign inst_seg      = i_inst_vaddr[VADDR_W-1 -: 3];
    assign data_seg      = i_data_vaddr[VADDR_W-1 -: 3];
    assign inst_unmapped = (inst_seg == SEG_KSEG0) || (inst_seg == SEG_KSEG1);
    assign data_unmapped = (data_seg == SEG_KSEG0) || (data_seg == SEG_KSEG1);

    assign o_inst_tag      = xlate_tag(inst_unmapped, i_inst_vaddr, i_inst_page);
    assign o_data_tag      = xlate_tag(data_unmapped, i_data_vaddr, i_data_page);
    assign o_inst_uncached = xlate_uncached(inst_seg, i_inst_found, i_inst_page);
    assign o_data_uncached = xlate_uncached(data_seg, i_data_found, i_data_page);

    // exceptions, mapped addresses only
    assign o_i_refill  = !inst_unmapped && i_inst_en && !i_inst_found;
    assign o_i_invalid = !inst_unmapped && i_inst_en && i_inst_found && !i_inst_page.v;

    assign data_access = i_data_ren || i_data_wen;
    assign o_d_refill  = !data_unmapped && data_access && !i_data_found;
    assign o_d_invalid = !data_unmapped && data_access && i_data_found && !i_data_page.v;
    // store to a valid clean page
    assign o_d_modify  = !data_unmapped && i_data_wen && i_data_found
                         && i_data_page.v && !i_data_page.d;

endmodule

/* testbench/tb_tlb.sv */
module tb_tlb
    import tlb_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int N_RW         = 40;
    localparam int N_SEARCH     = 200;
    localparam int N_MODIFY     = 20;
    localparam int N_KSEG       = 40;
    localparam int N_PROBE      = 60;
    // one op per cycle, write/read pairs and modify triples counted in full
    localparam int N_OPS = TLB_NUM + 2 * N_RW + N_SEARCH + 3 * N_MODIFY + N_KSEG + N_PROBE;
    localparam int CYCLE_LIMIT = 2 * N_OPS + RESET_CYCLES;
    // outside the vpn2 pool, so only the entry at index 0 hits
    localparam logic [VPN2_W-1:0] MOD_VPN2 = 19'h2_5A5A;

    logic                 clk;
    logic                 resetn;
    logic                 i_we;
    logic [TLB_IDX_W-1:0] i_w_index;
    logic [VADDR_W-1:0]   i_w_hi;
    logic [VADDR_W-1:0]   i_w_lo0;
    logic [VADDR_W-1:0]   i_w_lo1;
    logic [TLB_IDX_W-1:0] i_r_index;
    logic                 i_inst_en;
    logic [VADDR_W-1:0]   i_inst_vaddr;
    logic                 i_data_ren;
    logic                 i_data_wen;
    logic [VADDR_W-1:0]   i_data_vaddr;
    logic                 i_op_tlbp;
    logic [VADDR_W-1:0]   o_r_hi;
    logic [VADDR_W-1:0]   o_r_lo0;
    logic [VADDR_W-1:0]   o_r_lo1;
    logic [VADDR_W-1:0]   o_p_index;
    logic [PFN_W-1:0]     o_inst_tag;
    logic                 o_inst_uncached;
    logic [PFN_W-1:0]     o_data_tag;
    logic                 o_data_uncached;
    logic                 o_i_refill;
    logic                 o_i_invalid;
    logic                 o_d_refill;
    logic                 o_d_invalid;
    logic                 o_d_modify;

    // model of the stored images, g kept in lo bit 0
    logic [VADDR_W-1:0] m_hi  [TLB_NUM];
    logic [VADDR_W-1:0] m_lo0 [TLB_NUM];
    logic [VADDR_W-1:0] m_lo1 [TLB_NUM];
    logic [VPN2_W-1:0]  vpn2_pool [4];
    logic [ASID_W-1:0]  asid_pool [3];
    logic [31:0]        rng;
    int cycles    = 0;
    int checks    = 0;
    int errors    = 0;
    int test_errs = 0;
    int test_ops  = 0;
    int n_tests   = 0;

    tlb_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] rand_hi();
        logic [31:0] r;
        r = xorshift();
        return {vpn2_pool[r[1:0]], r[12:8], asid_pool[r[17:16] % 3]};
    endfunction

    function automatic logic [31:0] rand_mapped();
        logic [31:0] r;
        r = xorshift();
        return {vpn2_pool[r[31:30]], r[12:0]};
    endfunction

    function automatic logic [31:0] rand_lo();
        logic [31:0] r;
        r = xorshift();
        if (r[31]) begin
            r[5:3] = CACHE_UNCACHED;
        end
        return r;
    endfunction

    function automatic logic [31:0] hi_image(input logic [31:0] hi);
        return hi & 32'hFFFF_E0FF;
    endfunction

    function automatic logic [31:0] lo_image(input logic [31:0] lo, input logic g);
        return (lo & 32'h03FF_FFFE) | {31'b0, g};
    endfunction

    // lowest matching index, -1 on a miss
    function automatic int find_entry(input logic [VPN2_W-1:0] vpn2,
                                      input logic [ASID_W-1:0] asid);
        for (int k = 0; k < TLB_NUM; k++) begin
            if (m_hi[k][31:13] == vpn2 && (m_hi[k][7:0] == asid || m_lo0[k][0])) begin
                return k;
            end
        end
        return -1;
    endfunction

    task automatic check_val(input string port, input string field,
                             input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at time %0t: %s %s is %h, expected %h", $time, port, field, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    // exc is {refill, invalid, modify}
    task automatic check_port(
        input string              port,
        input logic [VADDR_W-1:0] va,
        input logic [VADDR_W-1:0] query,
        input logic               access,
        input logic               wr,
        input logic [PFN_W-1:0]   tag,
        input logic               unc,
        input logic [2:0]         exc,
        output int                idx
    );
        logic [31:0] lo;
        logic [2:0]  seg;
        logic        mapped;
        logic        hit;
        idx = find_entry(query[31:13], i_w_hi[7:0]);
        hit = (idx >= 0);
        lo  = 32'b0;
        if (hit) begin
            lo = query[ODD_BIT] ? m_lo1[idx] : m_lo0[idx];
        end
        seg    = va[31:29];
        mapped = (seg != SEG_KSEG0) && (seg != SEG_KSEG1);
        if (!mapped) begin
            check_val(port, "tag", tag, {3'b000, va[28:12]});
        end else if (hit) begin
            check_val(port, "tag", tag, lo[25:6]);
        end
        check_val(port, "uncached", unc,
                  (seg == SEG_KSEG1) || (mapped && hit && lo[5:3] == CACHE_UNCACHED));
        check_val(port, "exceptions", exc,
                  {mapped && access && !hit, mapped && access && hit && !lo[1],
                   mapped && wr && hit && lo[1] && !lo[2]});
    endtask

    task automatic check_outputs();
        int          inst_idx;
        int          data_idx;
        logic        g;
        g = i_w_lo0[0] & i_w_lo1[0];
        if (i_we && i_r_index == i_w_index) begin
            check_val("read", "hi", o_r_hi, hi_image(i_w_hi));
            check_val("read", "lo0", o_r_lo0, lo_image(i_w_lo0, g));
            check_val("read", "lo1", o_r_lo1, lo_image(i_w_lo1, g));
        end else begin
            check_val("read", "hi", o_r_hi, m_hi[i_r_index]);
            check_val("read", "lo0", o_r_lo0, m_lo0[i_r_index]);
            check_val("read", "lo1", o_r_lo1, m_lo1[i_r_index]);
        end
        check_port("inst", i_inst_vaddr, i_inst_vaddr, i_inst_en, 1'b0, o_inst_tag,
                   o_inst_uncached, {o_i_refill, o_i_invalid, 1'b0}, inst_idx);
        check_port("data", i_data_vaddr, i_op_tlbp ? i_w_hi : i_data_vaddr,
                   i_data_ren || i_data_wen, i_data_wen, o_data_tag, o_data_uncached,
                   {o_d_refill, o_d_invalid, o_d_modify}, data_idx);
        check_val("probe", "index", o_p_index,
                  (data_idx >= 0) ? 32'(data_idx) : PROBE_MISS);
    endtask

    // check late in the cycle, then let the write land at the edge
    task automatic step();
        #5;
        check_outputs();
        if (i_we) begin
            m_hi[i_w_index]  = hi_image(i_w_hi);
            m_lo0[i_w_index] = lo_image(i_w_lo0, i_w_lo0[0] & i_w_lo1[0]);
            m_lo1[i_w_index] = lo_image(i_w_lo1, i_w_lo0[0] & i_w_lo1[0]);
        end
        test_ops++;
        @(posedge clk);
        #1;
    endtask

    task automatic drive_idle();
        i_we         = 1'b0;
        i_w_index    = '0;
        i_w_lo0      = '0;
        i_w_lo1      = '0;
        i_r_index    = '0;
        i_inst_en    = 1'b0;
        i_inst_vaddr = '0;
        i_data_ren   = 1'b0;
        i_data_wen   = 1'b0;
        i_data_vaddr = '0;
        i_op_tlbp    = 1'b0;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %s finished: %0d ops, %0d errors", name, test_ops, test_errs);
        test_ops  = 0;
        test_errs = 0;
    endtask

    initial begin
        logic [31:0] r;
        vpn2_pool[0] = 19'h0_0012;
        vpn2_pool[1] = 19'h0_0345;
        vpn2_pool[2] = 19'h3_1C07;
        vpn2_pool[3] = 19'h7_F00F;
        asid_pool[0] = 8'h01;
        asid_pool[1] = 8'h22;
        asid_pool[2] = 8'hA5;
        rng    = 32'd30;
        resetn = 1'b0;
        i_w_hi = '0;
        drive_idle();
        for (int k = 0; k < TLB_NUM; k++) begin
            m_hi[k]  = '0;
            m_lo0[k] = '0;
            m_lo1[k] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b1;

        // zeroed entries match vpn2 0 with asid 0 and are invalid
        for (int k = 0; k < TLB_NUM; k++) begin
            r = xorshift();
            i_r_index    = k;
            i_inst_en    = 1'b1;
            i_data_ren   = r[0];
            i_data_wen   = !r[0];
            i_w_hi       = k[0] ? 32'b0 : rand_hi();
            i_inst_vaddr = k[0] ? {19'b0, r[12:0]} : rand_mapped();
            i_data_vaddr = k[0] ? {19'b0, r[25:13]} : rand_mapped();
            step();
        end
        end_test("reset");

        for (int k = 0; k < N_RW; k++) begin
            r = xorshift();
            drive_idle();
            i_we      = 1'b1;
            i_w_index = r[3:0];
            i_r_index = r[3:0];
            i_w_hi    = rand_hi();
            i_w_lo0   = rand_lo();
            i_w_lo1   = rand_lo();
            step();
            drive_idle();
            i_r_index = r[3:0];
            step();
        end
        end_test("write_read");

        for (int k = 0; k < N_SEARCH; k++) begin
            r = xorshift();
            drive_idle();
            i_w_hi       = rand_hi();
            i_r_index    = r[3:0];
            i_inst_en    = r[4];
            i_data_ren   = r[5];
            i_data_wen   = r[6];
            i_inst_vaddr = rand_mapped();
            i_data_vaddr = rand_mapped();
            if (r[10:8] == 3'd0) begin
                i_we      = 1'b1;
                i_w_index = r[15:12];
                i_w_lo0   = rand_lo();
                i_w_lo1   = rand_lo();
            end
            step();
        end
        end_test("search");

        for (int k = 0; k < N_MODIFY; k++) begin
            r = xorshift();
            drive_idle();
            i_we    = 1'b1;
            i_w_hi  = {MOD_VPN2, r[12:8], asid_pool[0]};
            // valid and clean on both pages
            i_w_lo0 = (rand_lo() & ~32'h6) | 32'h2;
            i_w_lo1 = (rand_lo() & ~32'h6) | 32'h2;
            step();
            i_we         = 1'b0;
            i_data_vaddr = {MOD_VPN2, r[0], r[27:16]};
            i_data_wen   = 1'b1;
            step();
            i_data_wen = 1'b0;
            i_data_ren = 1'b1;
            step();
        end
        end_test("modify");

        for (int k = 0; k < N_KSEG; k++) begin
            r = xorshift();
            drive_idle();
            i_w_hi       = rand_hi();
            i_inst_en    = r[0];
            i_data_ren   = r[1];
            i_data_wen   = r[2];
            i_inst_vaddr = {r[3] ? SEG_KSEG1 : SEG_KSEG0, 29'(xorshift())};
            i_data_vaddr = {r[4] ? SEG_KSEG1 : SEG_KSEG0, 29'(xorshift())};
            step();
        end
        end_test("unmapped");

        for (int k = 0; k < N_PROBE; k++) begin
            r = xorshift();
            drive_idle();
            i_op_tlbp    = 1'b1;
            i_w_hi       = rand_hi();
            i_inst_en    = r[0];
            i_inst_vaddr = rand_mapped();
            i_data_vaddr = rand_mapped();
            step();
        end
        end_test("probe");

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, checks, errors, DUT.u_checker.fail_count);
        if (errors == 0 && DUT.u_checker.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* testbench/tlb_checker.sv */
module tlb_checker
    import tlb_pkg::*;
(
    input logic               clk,
    input logic               resetn,
    input logic [VADDR_W-1:0] i_inst_vaddr,
    input logic [VADDR_W-1:0] i_data_vaddr,
    input logic               i_i_refill,
    input logic               i_i_invalid,
    input logic               i_d_refill,
    input logic               i_d_invalid,
    input logic               i_d_modify,
    input logic [VADDR_W-1:0] i_p_index
);

    logic inst_unmapped;
    logic data_unmapped;
    int   fail_count = 0;

    assign inst_unmapped = (i_inst_vaddr[31:29] == SEG_KSEG0)
                           || (i_inst_vaddr[31:29] == SEG_KSEG1);
    assign data_unmapped = (i_data_vaddr[31:29] == SEG_KSEG0)
                           || (i_data_vaddr[31:29] == SEG_KSEG1);

    a_inst_one_exc: assert property (@(posedge clk) disable iff (!resetn)
        !(i_i_refill && i_i_invalid))
        else begin
            fail_count++;
            $error("instruction refill and invalid raised together");
        end

    a_data_one_exc: assert property (@(posedge clk) disable iff (!resetn)
        !(i_d_refill && i_d_invalid))
        else begin
            fail_count++;
            $error("data refill and invalid raised together");
        end

    // kseg0/kseg1 never fault
    a_inst_unmapped: assert property (@(posedge clk) disable iff (!resetn)
        inst_unmapped |-> !(i_i_refill || i_i_invalid))
        else begin
            fail_count++;
            $error("exception on an unmapped instruction address");
        end

    a_data_unmapped: assert property (@(posedge clk) disable iff (!resetn)
        data_unmapped |-> !(i_d_refill || i_d_invalid || i_d_modify))
        else begin
            fail_count++;
            $error("exception on an unmapped data address");
        end

    a_probe_range: assert property (@(posedge clk) disable iff (!resetn)
        (i_p_index < TLB_NUM) || (i_p_index == PROBE_MISS))
        else begin
            fail_count++;
            $error("probe index neither a valid entry nor the miss value");
        end

endmodule

bind tlb_top tlb_checker u_checker (
    .clk          (clk),
    .resetn       (resetn),
    .i_inst_vaddr (i_inst_vaddr),
    .i_data_vaddr (i_data_vaddr),
    .i_i_refill   (o_i_refill),
    .i_i_invalid  (o_i_invalid),
    .i_d_refill   (o_d_refill),
    .i_d_invalid  (o_d_invalid),
    .i_d_modify   (o_d_modify),
    .i_p_index    (o_p_index)
);

/* tlb/tlb_cam.sv */
module tlb_cam
    import tlb_pkg::*;
(
    input  tlb_entry_t [TLB_NUM-1:0]    i_entries,
    input  logic [VADDR_W-1:0]          i_w_hi,
    input  logic                        i_op_tlbp,

    input  logic [VADDR_W-1:0]          i_inst_vaddr,
    input  logic [VADDR_W-1:0]          i_data_vaddr,

    output logic                        o_inst_found,
    output logic                        o_data_found,
    output tlb_page_t                   o_inst_page,
    output tlb_page_t                   o_data_page,
    output logic [VADDR_W-1:0]          o_p_index
);

    logic [ASID_W-1:0]    cur_asid;

    logic [VPN2_W-1:0]    inst_vpn2;
    logic                 inst_odd;
    logic [TLB_NUM-1:0]   inst_match;
    logic [TLB_IDX_W-1:0] inst_index;

    logic [VPN2_W-1:0]    data_vpn2;
    logic                 data_odd;
    logic [TLB_NUM-1:0]   data_match;
    logic [TLB_IDX_W-1:0] data_index;

    // per-entry compare, asid ignored for global entries
    function automatic logic [TLB_NUM-1:0] match_vec(
        input tlb_entry_t [TLB_NUM-1:0] ents,
        input logic [VPN2_W-1:0]        vpn2,
        input logic [ASID_W-1:0]        asid
    );
        logic [TLB_NUM-1:0] hit;
        for (int k = 0; k < TLB_NUM; k++) begin
            hit[k] = (ents[k].vpn2 == vpn2) && ((ents[k].asid == asid) || ents[k].g);
        end
        return hit;
    endfunction

    // lowest set bit wins
    function automatic logic [TLB_IDX_W-1:0] first_index(input logic [TLB_NUM-1:0] hit);
        logic [TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int k = TLB_NUM - 1; k >= 0; k--) begin
            if (hit[k]) begin
                idx = TLB_IDX_W'(k);
            end
        end
        return idx;
    endfunction

    function automatic tlb_page_t pick_page(
        input tlb_entry_t ent,
        input logic       odd,
        input logic       found
    );
        if (!found) begin
            return '0;
        end
        return odd ? ent.page1 : ent.page0;
    endfunction

    assign cur_asid = i_w_hi[ASID_W-1:0];

    // instruction port
    assign inst_vpn2    = i_inst_vaddr[VADDR_W-1 -: VPN2_W];
    assign inst_odd     = i_inst_vaddr[ODD_BIT];
    assign inst_match   = match_vec(i_entries, inst_vpn2, cur_asid);
    assign inst_index   = first_index(inst_match);
    assign o_inst_found = |inst_match;
    assign o_inst_page  = pick_page(i_entries[inst_index], inst_odd, o_inst_found);

    // data port, doubles as the probe search on tlbp
    assign data_vpn2    = i_op_tlbp ? i_w_hi[VADDR_W-1 -: VPN2_W]
                                    : i_data_vaddr[VADDR_W-1 -: VPN2_W];
    assign data_odd     = i_op_tlbp ? i_w_hi[ODD_BIT] : i_data_vaddr[ODD_BIT];
    assign data_match   = match_vec(i_entries, data_vpn2, cur_asid);
    assign data_index   = first_index(data_match);
    assign o_data_found = |data_match;
    assign o_data_page  = pick_page(i_entries[data_index], data_odd, o_data_found);

    assign o_p_index = o_data_found ? {{(VADDR_W-TLB_IDX_W){1'b0}}, data_index}
                                    : PROBE_MISS;

endmodule

/* tlb/tlb_entry_array.sv */
module tlb_entry_array
    import tlb_pkg::*;
(
    input  logic                        clk,
    input  logic                        resetn,

    input  logic                        i_we,
    input  logic [TLB_IDX_W-1:0]        i_w_index,
    input  logic [VADDR_W-1:0]          i_w_hi,
    input  logic [VADDR_W-1:0]          i_w_lo0,
    input  logic [VADDR_W-1:0]          i_w_lo1,

    input  logic [TLB_IDX_W-1:0]        i_r_index,

    output tlb_entry_t [TLB_NUM-1:0]    o_entries,
    output logic [VADDR_W-1:0]          o_r_hi,
    output logic [VADDR_W-1:0]          o_r_lo0,
    output logic [VADDR_W-1:0]          o_r_lo1
);

    tlb_entry_t [TLB_NUM-1:0] entries;
    tlb_entry_t               w_entry;
    tlb_entry_t               r_entry;
    logic                     r_bypass;

    // entry-lo image to page: pfn 25..6, c 5..3, d 2, v 1
    function automatic tlb_page_t lo_to_page(input logic [VADDR_W-1:0] lo);
        tlb_page_t pg;
        pg.pfn = lo[CACHE_W+3 +: PFN_W];
        pg.c   = lo[3 +: CACHE_W];
        pg.d   = lo[2];
        pg.v   = lo[1];
        return pg;
    endfunction

    function automatic logic [VADDR_W-1:0] page_to_lo(input tlb_page_t pg, input logic g);
        return {{(VADDR_W-PFN_W-CACHE_W-3){1'b0}}, pg.pfn, pg.c, pg.d, pg.v, g};
    endfunction

    // unpack the write images
    always_comb begin
        w_entry.vpn2  = i_w_hi[VADDR_W-1 -: VPN2_W];
        w_entry.asid  = i_w_hi[ASID_W-1:0];
        // g only when both halves agree
        w_entry.g     = i_w_lo0[0] & i_w_lo1[0];
        w_entry.page0 = lo_to_page(i_w_lo0);
        w_entry.page1 = lo_to_page(i_w_lo1);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            entries <= '0;
        end else if (i_we) begin
            entries[i_w_index] <= w_entry;
        end
    end

    assign o_entries = entries;

    // write to the read index shows up in the same cycle
    assign r_bypass = i_we && (i_r_index == i_w_index);
    assign r_entry  = r_bypass ? w_entry : entries[i_r_index];

    assign o_r_hi  = {r_entry.vpn2, {(VADDR_W-VPN2_W-ASID_W){1'b0}}, r_entry.asid};
    assign o_r_lo0 = page_to_lo(r_entry.page0, r_entry.g);
    assign o_r_lo1 = page_to_lo(r_entry.page1, r_entry.g);

endmodule
